// ==== arcade_consts.svh ====
/*
 * Arcade I/O front end constants
 * Player count, PS/2 frame length and sigma-delta DAC width
 * shared by the RTL and the testbench
 */

`ifndef ARCADE_CONSTS_SVH
`define ARCADE_CONSTS_SVH

// Number of player control ports driven to the game core
`define ARCADE_NUM_PLAYERS 2

// Start bit, eight data bits, odd parity and stop bit
`define PS2_FRAME_BITS 11

// Width of the sound mix and of the DAC accumulator
`define DAC_WIDTH 11

`endif

// ==== arcade_io.sv ====
/*
 * Arcade control and sound front end
 * PS/2 keyboard receiver and key tracker, one control mapper per
 * player, and the mixed sigma-delta audio output for the game core
 */

`timescale 1ns/1ns
`include "arcade_consts.svh"

module arcade_io import arcade_pkg::*; (
	input  logic                                clk_sys,
	input  logic                                arst_n,
	input  logic                                ps2_clk,
	input  logic                                ps2_data,
	input  joy_t                                joy0,
	input  joy_t                                joy1,
	input  logic                                rotate,
	input  sample_t                             snd_a,
	input  sample_t                             snd_b,
	output control_t [`ARCADE_NUM_PLAYERS-1:0]  players,
	output logic                                audio_out
);

	scancode_t  kbd_code;
	logic       kbd_req;
	logic       kbd_ack;
	key_state_t keys;

	// ==================================================
	// Keyboard path
	// ==================================================

	ps2_receiver rx0 (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.code     (kbd_code),
		.req      (kbd_req),
		.ack      (kbd_ack)
	);

	key_tracker trk0 (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.code    (kbd_code),
		.req     (kbd_req),
		.ack     (kbd_ack),
		.keys    (keys)
	);

	// One mapper per player, all fed by the same key table
	for (genvar p = 0; p < `ARCADE_NUM_PLAYERS; p++) begin : g_player
		control_mapper #(.PLAYER(p)) map (
			.clk_sys (clk_sys),
			.arst_n  (arst_n),
			.keys    (keys),
			.joy0    (joy0),
			.joy1    (joy1),
			.rotate  (rotate),
			.ctrl    (players[p])
		);
	end

	// ==================================================
	// Audio path
	// ==================================================

	audio_dac dac0 (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.snd_a     (snd_a),
		.snd_b     (snd_b),
		.audio_out (audio_out)
	);

endmodule

// ==== arcade_pkg.sv ====
/*
 * Arcade I/O front end types
 * Scancode, joystick and audio sample words, the held-key table,
 * the per-player control word and the PS/2 receiver states
 */

`include "arcade_consts.svh"

package arcade_pkg;

	typedef logic [7:0] scancode_t;
	// Bit 0 right, 1 left, 2 down, 3 up, 4 fire
	typedef logic [7:0] joy_t;
	typedef logic [7:0] sample_t;
	typedef logic [`DAC_WIDTH-1:0] mix_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic start1;
		logic start2;
		logic coin;
	} key_state_t;

	// Same bit order as the game core's CSJUDLR inputs
	typedef struct packed {
		logic coin;
		logic start;
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} control_t;

	typedef enum logic [1:0] {rx_idle, rx_shift, rx_offer, rx_wait_low} rx_state_t;

endpackage

// ==== audio_dac.sv ====
/*
 * Sound mixer and sigma-delta DAC
 * Mixes channel B at four times the weight of channel A and turns the
 * sum into a pulse-density stream with a first-order modulator
 */

`timescale 1ns/1ns
`include "arcade_consts.svh"

module audio_dac import arcade_pkg::*; (
	input  logic    clk_sys,
	input  logic    arst_n,
	input  sample_t snd_a,
	input  sample_t snd_b,
	output logic    audio_out
);

	sample_t                snd_a_q;
	sample_t                snd_b_q;
	mix_t                   mix;
	mix_t                   acc;
	logic [`DAC_WIDTH:0]    acc_sum;

	// Carry out of the accumulator is the output pulse
	assign acc_sum = {1'b0, acc} + {1'b0, mix};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			snd_a_q   <= '0;
			snd_b_q   <= '0;
			mix       <= '0;
			acc       <= '0;
			audio_out <= 1'b0;
		end else begin
			snd_a_q   <= snd_a;
			snd_b_q   <= snd_b;
			// Largest sum is 4 * 255 + 255 = 1275, well inside the range
			mix       <= mix_t'({snd_b_q, 2'b00}) + mix_t'(snd_a_q);
			acc       <= acc_sum[`DAC_WIDTH-1:0];
			audio_out <= acc_sum[`DAC_WIDTH];
		end
	end

endmodule

// ==== control_mapper.sv ====
/*
 * Player control mapper
 * ORs the keyboard table with both joysticks, rotates the directions
 * for an upright cabinet and registers the control word of one player
 */

`timescale 1ns/1ns

module control_mapper import arcade_pkg::*; #(
	parameter int PLAYER = 0
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  key_state_t keys,
	input  joy_t       joy0,
	input  joy_t       joy1,
	input  logic       rotate,
	output control_t   ctrl
);

	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	logic     raw_up;
	logic     raw_down;
	logic     raw_left;
	logic     raw_right;
	control_t ctrl_next;

	assign raw_up    = keys.up    | joy0[JOY_UP]    | joy1[JOY_UP];
	assign raw_down  = keys.down  | joy0[JOY_DOWN]  | joy1[JOY_DOWN];
	assign raw_left  = keys.left  | joy0[JOY_LEFT]  | joy1[JOY_LEFT];
	assign raw_right = keys.right | joy0[JOY_RIGHT] | joy1[JOY_RIGHT];

	always_comb begin
		ctrl_next.fire  = keys.fire | joy0[JOY_FIRE] | joy1[JOY_FIRE];
		ctrl_next.start = (PLAYER == 0) ? keys.start1 : keys.start2;
		// Only the first player has a coin slot
		ctrl_next.coin  = (PLAYER == 0) ? keys.coin : 1'b0;
		// Upright cabinet turns the screen a quarter turn
		ctrl_next.up    = rotate ? raw_left  : raw_up;
		ctrl_next.down  = rotate ? raw_right : raw_down;
		ctrl_next.left  = rotate ? raw_down  : raw_left;
		ctrl_next.right = rotate ? raw_up    : raw_right;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			ctrl <= '0;
		else
			ctrl <= ctrl_next;
	end

endmodule

// ==== key_tracker.sv ====
/*
 * Game key tracker
 * Takes scancodes from the PS/2 receiver, follows the E0 extended and
 * F0 release prefixes, and keeps the held state of the eight game keys
 */

`timescale 1ns/1ns

module key_tracker import arcade_pkg::*; (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  scancode_t  code,
	input  logic       req,
	output logic       ack,
	output key_state_t keys
);

	localparam scancode_t CODE_EXT = 8'hE0;
	localparam scancode_t CODE_REL = 8'hF0;

	logic       ext_seen;
	logic       rel_seen;
	key_state_t keys_next;

	// ==================================================
	// Scancode to key table update
	// ==================================================

	// A key is set on make and cleared when F0 came before it
	always_comb begin
		keys_next = keys;
		if (!ext_seen) begin
			case (code)
				8'h29:   keys_next.fire   = !rel_seen;
				8'h16:   keys_next.start1 = !rel_seen;
				8'h1E:   keys_next.start2 = !rel_seen;
				8'h2E:   keys_next.coin   = !rel_seen;
				default: keys_next = keys;
			endcase
		end else begin
			// Arrow keys only exist in the extended set
			case (code)
				8'h75:   keys_next.up    = !rel_seen;
				8'h72:   keys_next.down  = !rel_seen;
				8'h6B:   keys_next.left  = !rel_seen;
				8'h74:   keys_next.right = !rel_seen;
				default: keys_next = keys;
			endcase
		end
	end

	// ==================================================
	// Req/ack sink
	// ==================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ack      <= 1'b0;
			ext_seen <= 1'b0;
			rel_seen <= 1'b0;
			keys     <= '0;
		end else begin
			if (req && !ack) begin
				ack <= 1'b1;
				if (code == CODE_EXT) begin
					ext_seen <= 1'b1;
				end else if (code == CODE_REL) begin
					rel_seen <= 1'b1;
				end else begin
					// Any other code ends the prefix sequence
					keys     <= keys_next;
					ext_seen <= 1'b0;
					rel_seen <= 1'b0;
				end
			end else if (!req && ack) begin
				ack <= 1'b0;
			end
		end
	end

endmodule

// ==== list.f ====
+incdir+.
arcade_pkg.sv
ps2_receiver.sv
key_tracker.sv
control_mapper.sv
audio_dac.sv
arcade_io.sv
tb_arcade_io.sv

// ==== ps2_receiver.sv ====
/*
 * PS/2 keyboard receiver
 * Synchronizes the PS/2 clock and data lines, shifts in frames on the
 * falling clock edge, checks odd parity and the stop bit, and offers
 * each good byte to the key tracker by a four-phase req/ack handshake
 */

`timescale 1ns/1ns
`include "arcade_consts.svh"

module ps2_receiver import arcade_pkg::*; (
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      ps2_clk,
	input  logic      ps2_data,
	output scancode_t code,
	output logic      req,
	input  logic      ack
);

	localparam int STOP_BIT = `PS2_FRAME_BITS - 1;

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic       clk_prev;
	logic       fall;
	logic [3:0] bit_cnt;
	logic [8:0] shreg;
	logic       frame_done;
	logic       frame_good;
	rx_state_t  state;

	// ==================================================
	// Line synchronizers and frame shifter
	// ==================================================

	assign fall       = clk_prev & ~clk_sync[1];
	assign frame_done = fall && (bit_cnt == 4'(STOP_BIT));
	// Data plus parity must hold an odd number of ones, and stop must be 1
	assign frame_good = data_sync[1] & (^shreg);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			clk_sync  <= '0;
			data_sync <= '0;
			clk_prev  <= 1'b0;
			bit_cnt   <= '0;
			shreg     <= '0;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev  <= clk_sync[1];
			if (fall) begin
				if (bit_cnt == '0) begin
					// Only a low start bit opens a frame
					if (!data_sync[1])
						bit_cnt <= 4'd1;
				end else if (frame_done) begin
					bit_cnt <= '0;
				end else begin
					// LSB first, so new bits enter at the top
					shreg   <= {data_sync[1], shreg[8:1]};
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	// ==================================================
	// Handshake toward the key tracker
	// ==================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= rx_idle;
			code  <= '0;
			req   <= 1'b0;
		end else begin
			case (state)
				rx_idle, rx_shift: begin
					if (frame_done) begin
						if (frame_good) begin
							code  <= shreg[7:0];
							req   <= 1'b1;
							state <= rx_offer;
						end else begin
							state <= rx_idle;
						end
					end else if (fall && bit_cnt == '0 && !data_sync[1]) begin
						state <= rx_shift;
					end
				end
				// Frames that finish in these two states are lost
				rx_offer: begin
					if (ack) begin
						req   <= 1'b0;
						state <= rx_wait_low;
					end
				end
				rx_wait_low: begin
					if (!ack)
						state <= (bit_cnt != '0) ? rx_shift : rx_idle;
				end
				default: state <= rx_idle;
			endcase
		end
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the arcade I/O testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator was not found in PATH"
	exit 1
fi

verilator --binary --timing --assert --top-module tb_arcade_io -f list.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

sim_output=$(./obj_dir/Vtb_arcade_io 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Everything OK" <<< "$sim_output"; then
	exit 0
fi
echo "Simulation finished without the pass line"
exit 1

// ==== tb_arcade_io.sv ====
/*
 * Arcade I/O front end testbench
 * Sends PS/2 frames, drives joysticks and sound samples, and checks
 * the player control words and the audio bit stream against models
 */

`timescale 1ns/1ns
`include "arcade_consts.svh"

module tb_arcade_io import arcade_pkg::*; ();

	localparam int HALF_BIT      = 20;
	localparam int SETTLE_CYCLES = 10;
	localparam int NUM_RANDOM    = 16;
	localparam int NUM_DAC_PAIRS = 6;
	localparam int DAC_SETTLE    = 4;
	localparam int DAC_WINDOW    = 1 << `DAC_WIDTH;
	// Worst case frame counts of each test group
	localparam int MAX_FRAMES    = 4 * 3 + 2 * 4 * 5 + NUM_RANDOM * 3 + 6;
	localparam int WATCHDOG_CYCLES = (MAX_FRAMES * `PS2_FRAME_BITS * 2 * HALF_BIT +
		NUM_DAC_PAIRS * (DAC_WINDOW + DAC_SETTLE)) * 12 / 10;

	logic                               clk_sys;
	logic                               arst_n;
	logic                               ps2_clk;
	logic                               ps2_data;
	joy_t                               joy0;
	joy_t                               joy1;
	logic                               rotate;
	sample_t                            snd_a;
	sample_t                            snd_b;
	control_t [`ARCADE_NUM_PLAYERS-1:0] players;
	logic                               audio_out;

	// Reference key table and its prefix flags
	key_state_t model_keys;
	logic       model_ext;
	logic       model_rel;
	string      test_name;
	logic       check_pending;

	arcade_io dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		fail_run("Watchdog expired, the tests did not finish in time");
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// ==================================================
	// Reference models
	// ==================================================

	function automatic key_state_t model_apply(input key_state_t k, input scancode_t code,
		input logic ext, input logic rel);
		key_state_t nk;
		nk = k;
		if (!ext) begin
			case (code)
				8'h29:   nk.fire = ~rel;
				8'h16:   nk.start1 = ~rel;
				8'h1E:   nk.start2 = ~rel;
				8'h2E:   nk.coin = ~rel;
				default: ;
			endcase
		end else begin
			case (code)
				8'h75:   nk.up = ~rel;
				8'h72:   nk.down = ~rel;
				8'h6B:   nk.left = ~rel;
				8'h74:   nk.right = ~rel;
				default: ;
			endcase
		end
		return nk;
	endfunction

	function automatic control_t expected_ctrl(input key_state_t k, input joy_t j0,
		input joy_t j1, input logic rot, input int player);
		logic     up;
		logic     dn;
		logic     lf;
		logic     rt;
		control_t c;
		up = k.up | j0[3] | j1[3];
		dn = k.down | j0[2] | j1[2];
		lf = k.left | j0[1] | j1[1];
		rt = k.right | j0[0] | j1[0];
		c.coin  = (player == 0) ? k.coin : 1'b0;
		c.start = (player == 0) ? k.start1 : k.start2;
		c.fire  = k.fire | j0[4] | j1[4];
		c.up    = rot ? lf : up;
		c.down  = rot ? rt : dn;
		c.left  = rot ? dn : lf;
		c.right = rot ? up : rt;
		return c;
	endfunction

	function automatic int dac_expected_ones(input sample_t a, input sample_t b);
		return 4 * int'(b) + int'(a);
	endfunction

	// Keys 0 to 3 are plain codes, keys 4 to 7 are the extended arrows
	function automatic scancode_t key_code(input int idx);
		case (idx)
			0:       return 8'h29;
			1:       return 8'h16;
			2:       return 8'h1E;
			3:       return 8'h2E;
			4:       return 8'h75;
			5:       return 8'h72;
			6:       return 8'h6B;
			default: return 8'h74;
		endcase
	endfunction

	// ==================================================
	// Stimulus tasks
	// ==================================================

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic send_frame(input scancode_t code, input logic bad_parity);
		logic [10:0] frame;
		frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
		wait_cycles(1);
		for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
			ps2_data = frame[0];
			frame = frame >> 1;
			wait_cycles(HALF_BIT);
			ps2_clk = 1'b0;
			wait_cycles(HALF_BIT);
			ps2_clk = 1'b1;
		end
	endtask

	task automatic send_code(input scancode_t code, input logic bad_parity);
		send_frame(code, bad_parity);
		if (!bad_parity) begin
			if (code == 8'hE0) begin
				model_ext = 1'b1;
			end else if (code == 8'hF0) begin
				model_rel = 1'b1;
			end else begin
				model_keys = model_apply(model_keys, code, model_ext, model_rel);
				model_ext = 1'b0;
				model_rel = 1'b0;
			end
		end
	endtask

	task automatic send_key(input int idx, input logic is_release);
		if (idx >= 4)
			send_code(8'hE0, 1'b0);
		if (is_release)
			send_code(8'hF0, 1'b0);
		send_code(key_code(idx), 1'b0);
	endtask

	task automatic run_check(input string name);
		test_name = name;
		check_pending = 1'b1;
		wait (check_pending == 1'b0);
		wait_cycles(1);
	endtask

	task automatic check_dac(input sample_t a, input sample_t b, input string name);
		int ones;
		int expected;
		ones = 0;
		snd_a = a;
		snd_b = b;
		wait_cycles(DAC_SETTLE);
		for (int i = 0; i < DAC_WINDOW; i++) begin
			@(negedge clk_sys);
			if (audio_out)
				ones++;
		end
		expected = dac_expected_ones(a, b);
		assert (ones == expected) else
			fail_run($sformatf("MISMATCH test=%s expected=%0d actual=%0d",
				name, expected, ones));
		wait_cycles(1);
	endtask

	// ==================================================
	// Comparison process
	// ==================================================

	initial begin
		control_t exp0;
		control_t exp1;
		forever begin
			wait (check_pending == 1'b1);
			repeat (SETTLE_CYCLES) @(posedge clk_sys);
			@(negedge clk_sys);
			exp0 = expected_ctrl(model_keys, joy0, joy1, rotate, 0);
			exp1 = expected_ctrl(model_keys, joy0, joy1, rotate, 1);
			assert (players[0] == exp0) else
				fail_run($sformatf("MISMATCH test=%s player=0 expected=%b actual=%b",
					test_name, exp0, players[0]));
			assert (players[1] == exp1) else
				fail_run($sformatf("MISMATCH test=%s player=1 expected=%b actual=%b",
					test_name, exp1, players[1]));
			check_pending = 1'b0;
		end
	end

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		int idx;
		int ones;
		arst_n = 1'b0;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		joy0 = '0;
		joy1 = '0;
		rotate = 1'b0;
		snd_a = '0;
		snd_b = '0;
		model_keys = '0;
		model_ext = 1'b0;
		model_rel = 1'b0;
		check_pending = 1'b0;
		test_name = "";
		void'($urandom(70712));
		wait_cycles(8);
		arst_n = 1'b1;

		// Quiet state straight after reset
		ones = 0;
		for (int i = 0; i < 64; i++) begin
			@(negedge clk_sys);
			if (audio_out)
				ones++;
		end
		assert (players == '0) else
			fail_run("Player words are not zero after reset");
		assert (ones == 0) else
			fail_run("Audio output toggled with silent inputs after reset");
		wait_cycles(1);

		for (int k = 0; k < 4; k++) begin
			send_key(k, 1'b0);
			run_check($sformatf("plain key %0d press", k));
			send_key(k, 1'b1);
			run_check($sformatf("plain key %0d release", k));
		end

		for (int r = 0; r < 2; r++) begin
			rotate = (r == 1);
			for (int k = 4; k < 8; k++) begin
				send_key(k, 1'b0);
				run_check($sformatf("arrow %0d rotate %0d press", k, r));
				send_key(k, 1'b1);
				run_check($sformatf("arrow %0d rotate %0d release", k, r));
			end
		end

		for (int n = 0; n < NUM_RANDOM; n++) begin
			idx = $urandom_range(7, 0);
			send_key(idx, $urandom_range(1, 0) == 1);
			joy0 = joy_t'($urandom);
			joy1 = joy_t'($urandom);
			rotate = ($urandom_range(1, 0) == 1);
			run_check($sformatf("random merge %0d", n));
		end

		// Corrupted frame must leave the table alone
		joy0 = '0;
		joy1 = '0;
		rotate = 1'b0;
		send_key(0, 1'b1);
		run_check("parity setup");
		send_code(8'h29, 1'b1);
		run_check("bad parity frame");
		send_code(8'h29, 1'b0);
		run_check("good frame after bad parity");
		send_key(0, 1'b1);
		run_check("parity cleanup");

		check_dac(8'd255, 8'd255, "dac full scale");
		for (int n = 1; n < NUM_DAC_PAIRS; n++)
			check_dac(sample_t'($urandom), sample_t'($urandom),
				$sformatf("dac pair %0d", n));

		$display("Everything OK");
		$finish;
	end

endmodule
